// File: compile.f
hires_pkg.sv
hires_phase_gen.sv
hires_matrix_counter.sv
hires_addressgen.sv
hires_video_ram.sv
hires_pixel_sequencer.sv
hires_video_top.sv
tb_hires_video.sv

// File: tb_hires_video.sv
`timescale 1ns/10ps

module tb_hires_video;
    import hires_pkg::*;

    localparam int cycles_per_line = 65;
    localparam int lines_per_frame = 20;
    localparam int visible_lines   = 16;
    localparam int frame_ticks     = lines_per_frame * cycles_per_line * phase_count;
    // display_en is high from phase 10 of cycle 14 to phase 9 of cycle 54
    localparam int first_tick      = fetch_first_cycle * phase_count + 10;
    localparam int last_tick       = (fetch_last_cycle + 1) * phase_count + 9;
    localparam int active_ticks    = visible_lines * chars_per_line * phase_count;
    // six frames plus one spare line each, the margin covers the RAM loads
    localparam int timeout_cycles  = 6 * (lines_per_frame + 1) * cycles_per_line *
                                     phase_count + 20000;

    logic        clk_dot4x;
    logic        arst_n;
    hires_mode_t hires_mode;
    logic [2:0]  char_pixel_base;
    logic [3:0]  matrix_base;
    logic [3:0]  color_base;
    logic        char_case;
    logic [3:0]  background_color;
    logic        cpu_we;
    logic [14:0] cpu_addr;
    logic [7:0]  cpu_data;
    logic [3:0]  pixel_color;
    logic        display_en;

    // mirror of every byte written into the video RAM
    logic [7:0]  shadow [0:32767];
    integer      seed;
    int          test_num;
    int          test_checks;
    int          test_errors;
    int          total_checks;
    int          errors;
    int          cycle_count;
    int          edge_idx;
    int          en_ticks;
    int          cur_line;
    int          cur_cycle;
    int          cur_phase;
    logic        checking;

    hires_video_top #(
        .cycles_per_line(cycles_per_line),
        .lines_per_frame(lines_per_frame),
        .visible_lines  (visible_lines)
    ) uut (
        .clk_dot4x       (clk_dot4x),
        .arst_n          (arst_n),
        .hires_mode      (hires_mode),
        .char_pixel_base (char_pixel_base),
        .matrix_base     (matrix_base),
        .color_base      (color_base),
        .char_case       (char_case),
        .background_color(background_color),
        .cpu_we          (cpu_we),
        .cpu_addr        (cpu_addr),
        .cpu_data        (cpu_data),
        .pixel_color     (pixel_color),
        .display_en      (display_en)
    );

    always #10 clk_dot4x = ~clk_dot4x;

    // expected color of one pixel, worked out from the counter rules
    function automatic logic [3:0] expected_color(input hires_mode_t mode,
                                                  input logic [2:0] cpb,
                                                  input logic [3:0] mb,
                                                  input logic [3:0] cb,
                                                  input logic cc,
                                                  input logic [3:0] bg,
                                                  input int line,
                                                  input int col,
                                                  input int pix);
        logic [10:0] vc;
        logic [2:0]  rc;
        logic [13:0] fvc;
        logic [7:0]  ch;
        logic [7:0]  pixels;
        logic [7:0]  color;
        logic [7:0]  plane;
        logic [3:0]  result;
        // text rows are 8 raster lines high, the bitmap runs on linearly
        vc  = 11'(chars_per_line * (line / 8) + col);
        rc  = 3'(line % 8);
        fvc = 14'(chars_per_line * line + col);
        case (mode)
            mode_text: begin
                ch     = shadow[{mb, vc}];
                pixels = shadow[{cpb, cc, ch, rc}];
                color  = shadow[{cb, vc}];
                // bit 4 of the color byte is the reverse flag
                result = (pixels[7 - pix] ^ color[4]) ? color[3:0] : bg;
            end
            mode_bitmap: begin
                pixels = shadow[{mb[0], fvc}];
                color  = shadow[{cb, vc}];
                result = pixels[7 - pix] ? color[7:4] : color[3:0];
            end
            default: begin
                pixels = shadow[{1'b0, fvc}];
                plane  = shadow[{1'b1, fvc}];
                result = {2'b00, plane[7 - pix], pixels[7 - pix]};
            end
        endcase
        return result;
    endfunction

    function automatic logic [7:0] random_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    task automatic report_mismatch(input string name, input logic [3:0] got,
                                   input logic [3:0] expected);
        test_errors++;
        // only the first few per test, a broken frame would flood the log
        if (test_errors <= 8) begin
            $display("Error: %s = %h, expected %h at line %0d cycle %0d phase %0d",
                     name, got, expected, cur_line, cur_cycle, cur_phase);
        end
    endtask

    // compares both outputs after every rising edge of the frame
    always @(negedge clk_dot4x) begin : compare_tick
        int         t;
        int         offset;
        logic       exp_en;
        logic [3:0] exp_color;
        if (checking) begin
            cur_phase = edge_idx % phase_count;
            cur_cycle = (edge_idx / phase_count) % cycles_per_line;
            cur_line  = edge_idx / (phase_count * cycles_per_line);
            t = cur_cycle * phase_count + cur_phase;
            exp_en = cur_line < visible_lines && t >= first_tick && t <= last_tick;
            exp_color = background_color;
            if (exp_en) begin
                // each pixel is held for two ticks, one column per phi cycle
                offset = t - first_tick;
                exp_color = expected_color(hires_mode, char_pixel_base, matrix_base,
                                           color_base, char_case, background_color,
                                           cur_line, offset / phase_count,
                                           (offset % phase_count) / 2);
            end
            test_checks += 2;
            assert (display_en === exp_en)
            else report_mismatch("display_en", {3'b000, display_en}, {3'b000, exp_en});
            assert (pixel_color === exp_color)
            else report_mismatch("pixel_color", pixel_color, exp_color);
            if (display_en === 1'b1) begin
                en_ticks++;
            end
            edge_idx++;
            if (edge_idx == frame_ticks) begin
                checking = 1'b0;
            end
        end
    end

    task automatic write_byte(input logic [14:0] addr, input logic [7:0] data);
        @(negedge clk_dot4x);
        cpu_we   = 1'b1;
        cpu_addr = addr;
        cpu_data = data;
        shadow[addr] = data;
    endtask

    // outputs must sit at zero for as long as reset is held
    task automatic assert_reset();
        @(negedge clk_dot4x);
        arst_n = 1'b0;
        repeat (2) begin
            @(negedge clk_dot4x);
            test_checks += 2;
            assert (display_en === 1'b0)
            else report_mismatch("display_en", {3'b000, display_en}, 4'h0);
            assert (pixel_color === 4'h0)
            else report_mismatch("pixel_color", pixel_color, 4'h0);
        end
    endtask

    task automatic release_reset();
        @(negedge clk_dot4x);
        cpu_we = 1'b0;
        @(negedge clk_dot4x);
        arst_n = 1'b1;
    endtask

    // the first phi cycle after release lies well before the fetch window
    task automatic check_after_release();
        repeat (phase_count) begin
            @(negedge clk_dot4x);
            test_checks += 2;
            assert (display_en === 1'b0)
            else report_mismatch("display_en", {3'b000, display_en}, 4'h0);
            assert (pixel_color === 4'h0)
            else report_mismatch("pixel_color", pixel_color, 4'h0);
        end
    endtask

    // the first rising edge after release is edge 0 of the frame
    task automatic run_frame();
        @(posedge clk_dot4x);
        edge_idx = 0;
        en_ticks = 0;
        checking = 1'b1;
        wait (!checking);
        assert (en_ticks == active_ticks)
        else begin
            $display("display_en was high for %0d ticks in the frame instead of %0d",
                     en_ticks, active_ticks);
            test_errors++;
        end
    endtask

    task automatic load_text(input logic reverse, input logic both_halves);
        logic [7:0] value;
        // two text rows of char pointers and color bytes
        for (int i = 0; i < 2 * chars_per_line; i++) begin
            write_byte({matrix_base, 11'(i)}, random_byte());
            value = random_byte();
            value[4] = reverse;
            write_byte({color_base, 11'(i)}, value);
        end
        for (int h = 0; h < 2; h++) begin
            if (both_halves || 1'(h) == char_case) begin
                for (int i = 0; i < 2048; i++) begin
                    write_byte({char_pixel_base, 1'(h), 11'(i)}, random_byte());
                end
            end
        end
    endtask

    task automatic load_bitmap();
        for (int i = 0; i < visible_lines * chars_per_line; i++) begin
            write_byte({matrix_base[0], 14'(i)}, random_byte());
        end
        for (int i = 0; i < 2 * chars_per_line; i++) begin
            write_byte({color_base, 11'(i)}, random_byte());
        end
    endtask

    task automatic load_planes();
        for (int i = 0; i < visible_lines * chars_per_line; i++) begin
            write_byte({1'b0, 14'(i)}, random_byte());
            write_byte({1'b1, 14'(i)}, random_byte());
        end
    endtask

    task automatic finish_test(input string name);
        test_num++;
        $display("test %0d %s: %0d checks, %0d errors", test_num, name,
                 test_checks, test_errors);
        total_checks += test_checks;
        errors += test_errors;
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk_dot4x);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the tests did not complete", cycle_count);
        $display("sim failed");
        $finish;
    end

    initial begin
        seed = 90532;
        clk_dot4x = 1'b0;
        arst_n = 1'b0;
        hires_mode = mode_text;
        char_pixel_base = 3'd0;
        matrix_base = 4'h0;
        color_base = 4'h0;
        char_case = 1'b0;
        background_color = 4'h0;
        cpu_we = 1'b0;
        cpu_addr = '0;
        cpu_data = '0;
        checking = 1'b0;
        edge_idx = 0;
        en_ticks = 0;
        test_num = 0;
        test_checks = 0;
        test_errors = 0;
        total_checks = 0;
        errors = 0;

        // background_color is 0 here, so the idle output keeps the reset value
        assert_reset();
        release_reset();
        check_after_release();
        finish_test("reset");

        // glyphs at 0x0000, pointers at 0x1000 and colors at 0x1800
        assert_reset();
        hires_mode = mode_text;
        char_pixel_base = 3'd0;
        matrix_base = 4'h2;
        color_base = 4'h3;
        char_case = 1'b0;
        background_color = 4'h6;
        load_text(1'b0, 1'b0);
        release_reset();
        run_frame();
        finish_test("text mode");

        // both glyph halves differ, so only the upper one may match
        assert_reset();
        char_pixel_base = 3'd5;
        matrix_base = 4'h8;
        color_base = 4'h9;
        char_case = 1'b1;
        background_color = 4'hb;
        load_text(1'b1, 1'b1);
        release_reset();
        run_frame();
        finish_test("text reverse and char_case");

        assert_reset();
        hires_mode = mode_bitmap;
        matrix_base = 4'h1;
        color_base = 4'h6;
        background_color = 4'h3;
        load_bitmap();
        release_reset();
        run_frame();
        finish_test("bitmap mode");

        assert_reset();
        hires_mode = mode_planes;
        load_planes();
        release_reset();
        run_frame();
        finish_test("planes mode 2'b10");

        assert_reset();
        hires_mode = mode_planes_alt;
        load_planes();
        release_reset();
        run_frame();
        finish_test("planes mode 2'b11");

        // lines 16 to 19 must show only the background color
        assert_reset();
        hires_mode = mode_bitmap;
        matrix_base = 4'h0;
        color_base = 4'ha;
        background_color = 4'hf;
        load_bitmap();
        release_reset();
        run_frame();
        finish_test("window edges");

        $display("%0d tests, %0d checks, %0d errors", test_num, total_checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: hires_video_top.sv
`timescale 1ns/10ps

module hires_video_top #(
    parameter int cycles_per_line = 65,
    parameter int lines_per_frame = 263,
    parameter int visible_lines   = 200
) (
    input  logic                   clk_dot4x,
    input  logic                   arst_n,
    input  hires_pkg::hires_mode_t hires_mode,
    input  logic [2:0]             char_pixel_base,
    input  logic [3:0]             matrix_base,
    input  logic [3:0]             color_base,
    input  logic                   char_case,
    input  logic [3:0]             background_color,
    input  logic                   cpu_we,
    input  logic [14:0]            cpu_addr,
    input  logic [7:0]             cpu_data,
    output logic [3:0]             pixel_color,
    output logic                   display_en
);

    logic [15:0] phi_phase_start;
    logic        clk_phi;
    logic [6:0]  cycle_num;
    logic [8:0]  raster_line;
    logic        display_line;
    logic [10:0] vc;
    logic [2:0]  rc;
    logic [13:0] fvc;
    logic [14:0] video_mem_addr;
    logic [7:0]  video_mem_data;
    logic [7:0]  hires_pixel_data;
    logic [7:0]  hires_color_data;

    hires_phase_gen #(
        .cycles_per_line(cycles_per_line),
        .lines_per_frame(lines_per_frame),
        .visible_lines  (visible_lines)
    ) u_phase_gen (
        .clk_dot4x      (clk_dot4x),
        .arst_n         (arst_n),
        .phi_phase_start(phi_phase_start),
        .clk_phi        (clk_phi),
        .cycle_num      (cycle_num),
        .raster_line    (raster_line),
        .display_line   (display_line)
    );

    hires_matrix_counter #(
        .visible_lines(visible_lines)
    ) u_matrix_counter (
        .clk_dot4x      (clk_dot4x),
        .arst_n         (arst_n),
        .phi_phase_start(phi_phase_start),
        .cycle_num      (cycle_num),
        .raster_line    (raster_line),
        .display_line   (display_line),
        .vc             (vc),
        .rc             (rc),
        .fvc            (fvc)
    );

    hires_addressgen u_addressgen (
        .clk_dot4x       (clk_dot4x),
        .arst_n          (arst_n),
        .clk_phi         (clk_phi),
        .phi_phase_start (phi_phase_start),
        .cycle_num       (cycle_num),
        .char_pixel_base (char_pixel_base),
        .matrix_base     (matrix_base),
        .color_base      (color_base),
        .rc              (rc),
        .vc              (vc),
        .fvc             (fvc),
        .char_case       (char_case),
        .hires_mode      (hires_mode),
        .video_mem_data  (video_mem_data),
        .video_mem_addr  (video_mem_addr),
        .hires_pixel_data(hires_pixel_data),
        .hires_color_data(hires_color_data)
    );

    // CPU writes share the RAM with the video fetch on a separate port
    hires_video_ram u_video_ram (
        .clk_dot4x(clk_dot4x),
        .rd_addr  (video_mem_addr),
        .rd_data  (video_mem_data),
        .we       (cpu_we),
        .wr_addr  (cpu_addr),
        .wr_data  (cpu_data)
    );

    hires_pixel_sequencer u_pixel_sequencer (
        .clk_dot4x       (clk_dot4x),
        .arst_n          (arst_n),
        .phi_phase_start (phi_phase_start),
        .cycle_num       (cycle_num),
        .display_line    (display_line),
        .hires_mode      (hires_mode),
        .hires_pixel_data(hires_pixel_data),
        .hires_color_data(hires_color_data),
        .background_color(background_color),
        .pixel_color     (pixel_color),
        .display_en      (display_en)
    );

endmodule

// File: hires_pixel_sequencer.sv
`timescale 1ns/10ps

module hires_pixel_sequencer (
    input  logic                   clk_dot4x,
    input  logic                   arst_n,
    input  logic [15:0]            phi_phase_start,
    input  logic [6:0]             cycle_num,
    input  logic                   display_line,
    input  hires_pkg::hires_mode_t hires_mode,
    input  logic [7:0]             hires_pixel_data,
    input  logic [7:0]             hires_color_data,
    input  logic [3:0]             background_color,
    output logic [3:0]             pixel_color,
    output logic                   display_en
);
    import hires_pkg::*;

    // even phases apart from the load phase, one pixel every 2 ticks
    localparam logic [15:0] shift_phases = 16'h5155;

    color_byte_u color_q;
    logic [7:0]  pixel_shift;
    logic [7:0]  plane_shift;
    logic        load;
    logic        step;

    // pix is the bitmap bit, plane is the second bitplane bit
    function automatic logic [3:0] decode_pixel(input hires_mode_t mode,
                                                input logic pix,
                                                input logic plane,
                                                input color_byte_u color,
                                                input logic [3:0] bg);
        logic [3:0] result;
        case (mode)
            mode_text:   result = (pix ^ color.text.reverse) ? color.text.fg : bg;
            mode_bitmap: result = pix ? color.bitmap.fg : color.bitmap.bg;
            default:     result = {2'b00, plane, pix};
        endcase
        return result;
    endfunction

    assign load = display_line && phi_phase_start[10] &&
                  cycle_num >= 7'(fetch_first_cycle) &&
                  cycle_num <= 7'(fetch_last_cycle);

    assign step = display_en && |(phi_phase_start & shift_phases);

    // first pixel goes straight out of the fetched bytes at load time
    always_ff @(posedge clk_dot4x or negedge arst_n) begin
        if (!arst_n) begin
            display_en  <= 1'b0;
            pixel_color <= '0;
        end else if (load) begin
            display_en  <= 1'b1;
            pixel_color <= decode_pixel(hires_mode, hires_pixel_data[7],
                                        hires_color_data[7], hires_color_data,
                                        background_color);
        end else if (display_en && phi_phase_start[10]) begin
            // no load after the last fetch cycle ends the active area
            display_en  <= 1'b0;
            pixel_color <= background_color;
        end else if (step) begin
            pixel_color <= decode_pixel(hires_mode, pixel_shift[7],
                                        plane_shift[7], color_q,
                                        background_color);
        end else if (!display_en) begin
            pixel_color <= background_color;
        end
    end

    // shift registers hold the remaining seven bits after the load
    always_ff @(posedge clk_dot4x) begin
        if (load) begin
            pixel_shift <= {hires_pixel_data[6:0], 1'b0};
            plane_shift <= {hires_color_data[6:0], 1'b0};
            color_q     <= hires_color_data;
        end else if (step) begin
            pixel_shift <= {pixel_shift[6:0], 1'b0};
            plane_shift <= {plane_shift[6:0], 1'b0};
        end
    end

endmodule

// File: hires_video_ram.sv
`timescale 1ns/10ps

module hires_video_ram (
    input  logic        clk_dot4x,
    input  logic [14:0] rd_addr,
    output logic [7:0]  rd_data,
    input  logic        we,
    input  logic [14:0] wr_addr,
    input  logic [7:0]  wr_data
);

    logic [7:0] mem [0:32767];

    // the address arrives from a register in the address generator, so
    // with the output register a read takes two ticks end to end
    always_ff @(posedge clk_dot4x) begin
        rd_data <= mem[rd_addr];
    end

    // write port is free running and never waits on the video fetch
    always_ff @(posedge clk_dot4x) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

endmodule

// File: hires_addressgen.sv
`timescale 1ns/10ps

module hires_addressgen (
    input  logic                  clk_dot4x,
    input  logic                  arst_n,
    input  logic                  clk_phi,
    input  logic [15:0]           phi_phase_start,
    input  logic [6:0]            cycle_num,
    input  logic [2:0]            char_pixel_base,
    input  logic [3:0]            matrix_base,
    input  logic [3:0]            color_base,
    input  logic [2:0]            rc,
    input  logic [10:0]           vc,
    input  logic [13:0]           fvc,
    input  logic                  char_case,
    input  hires_pkg::hires_mode_t hires_mode,
    input  logic [7:0]            video_mem_data,
    output logic [14:0]           video_mem_addr,
    output logic [7:0]            hires_pixel_data,
    output logic [7:0]            hires_color_data
);
    import hires_pkg::*;

    logic in_window;
    logic fetch_cycle;

    // window runs from the phi high half of cycle 14 to the phi low half
    // of cycle 54, so phases 2, 4 and 6 only fire in cycles 14 to 53
    assign in_window = (cycle_num == 7'(fetch_first_cycle) && clk_phi) ||
                       (cycle_num > 7'(fetch_first_cycle) &&
                        cycle_num <= 7'(fetch_last_cycle)) ||
                       (cycle_num == 7'(fetch_last_cycle + 1) && !clk_phi);

    // phase 8 of the first fetch cycle falls in the phi low half, so the
    // color capture follows the fetch cycles themselves
    assign fetch_cycle = cycle_num >= 7'(fetch_first_cycle) &&
                         cycle_num <= 7'(fetch_last_cycle);

    // each address set here shows up as RAM data two ticks later
    always_ff @(posedge clk_dot4x or negedge arst_n) begin
        if (!arst_n) begin
            video_mem_addr   <= '0;
            hires_pixel_data <= '0;
            hires_color_data <= '0;
        end else begin
            if (in_window && phi_phase_start[2]) begin
                // char pointer in text mode, ignored by the other modes
                video_mem_addr <= {matrix_base, vc};
            end else if (in_window && phi_phase_start[4]) begin
                case (hires_mode)
                    // the char pointer arrives just in time to index the glyph
                    mode_text:   video_mem_addr <= {char_pixel_base, char_case,
                                                    video_mem_data, rc};
                    mode_bitmap: video_mem_addr <= {matrix_base[0], fvc};
                    // first bitplane sits in the lower half of the RAM
                    default:     video_mem_addr <= {1'b0, fvc};
                endcase
            end else if (in_window && phi_phase_start[6]) begin
                hires_pixel_data <= video_mem_data;
                case (hires_mode)
                    mode_text,
                    mode_bitmap: video_mem_addr <= {color_base, vc};
                    // second bitplane replaces the color byte
                    default:     video_mem_addr <= {1'b1, fvc};
                endcase
            end
            // color byte is ready for the sequencer load at phase 10
            if (fetch_cycle && phi_phase_start[8]) begin
                hires_color_data <= video_mem_data;
            end
        end
    end

endmodule

// File: hires_matrix_counter.sv
`timescale 1ns/10ps

module hires_matrix_counter #(
    parameter int visible_lines = 200
) (
    input  logic        clk_dot4x,
    input  logic        arst_n,
    input  logic [15:0] phi_phase_start,
    input  logic [6:0]  cycle_num,
    input  logic [8:0]  raster_line,
    input  logic        display_line,
    output logic [10:0] vc,
    output logic [2:0]  rc,
    output logic [13:0] fvc
);
    import hires_pkg::*;

    // start of the current character row in the matrix
    logic [10:0] row_base;
    logic [10:0] next_row_base;
    logic        fetch_cycle;
    logic        frame_start;
    logic        vblank;
    logic        char_step;
    logic        line_end;

    assign fetch_cycle = cycle_num >= 7'(fetch_first_cycle) &&
                         cycle_num <= 7'(fetch_last_cycle);

    // very first tick of raster line 0, well before the fetch window
    assign frame_start = raster_line == 9'd0 && cycle_num == 7'd0 &&
                         phi_phase_start[0];

    // counters sit cleared below the visible area
    assign vblank = raster_line >= 9'(visible_lines);

    // step after the fetch of each cycle has used the current count
    assign char_step = display_line && fetch_cycle && phi_phase_start[10];

    // the first cycle past the window closes the line
    assign line_end = display_line && phi_phase_start[10] &&
                      cycle_num == 7'(fetch_last_cycle + 1);

    assign next_row_base = row_base + 11'(chars_per_line);

    always_ff @(posedge clk_dot4x or negedge arst_n) begin
        if (!arst_n) begin
            row_base <= '0;
            vc       <= '0;
            rc       <= '0;
            fvc      <= '0;
        end else if (frame_start || vblank) begin
            row_base <= '0;
            vc       <= '0;
            rc       <= '0;
            fvc      <= '0;
        end else if (char_step) begin
            vc  <= vc + 11'd1;
            // the bitmap counter never rewinds within a frame
            fvc <= fvc + 14'd1;
        end else if (line_end) begin
            rc <= rc + 3'd1;
            if (rc == 3'd7) begin
                // last glyph row done, move on to the next text row
                row_base <= next_row_base;
                vc       <= next_row_base;
            end else begin
                // same text row again for the next glyph row
                vc <= row_base;
            end
        end
    end

endmodule

// File: hires_phase_gen.sv
`timescale 1ns/10ps

module hires_phase_gen #(
    parameter int cycles_per_line = 65,
    parameter int lines_per_frame = 263,
    parameter int visible_lines   = 200
) (
    input  logic        clk_dot4x,
    input  logic        arst_n,
    output logic [15:0] phi_phase_start,
    output logic        clk_phi,
    output logic [6:0]  cycle_num,
    output logic [8:0]  raster_line,
    output logic        display_line
);
    import hires_pkg::*;

    logic [3:0] phase;
    logic       last_phase;
    logic       last_cycle;
    logic       last_line;

    assign last_phase = phase == 4'(phase_count - 1);
    assign last_cycle = cycle_num == 7'(cycles_per_line - 1);
    assign last_line  = raster_line == 9'(lines_per_frame - 1);

    // the phase runs every tick, the cycle steps after phase 15 and the
    // raster line steps when the cycle wraps
    always_ff @(posedge clk_dot4x or negedge arst_n) begin
        if (!arst_n) begin
            phase       <= '0;
            cycle_num   <= '0;
            raster_line <= '0;
        end else begin
            phase <= phase + 4'd1;
            if (last_phase) begin
                if (last_cycle) begin
                    cycle_num <= '0;
                    // frame wrap back to the top line
                    raster_line <= last_line ? 9'd0 : raster_line + 9'd1;
                end else begin
                    cycle_num <= cycle_num + 7'd1;
                end
            end
        end
    end

    // one strobe per tick, bit n marks tick n of the phi cycle
    assign phi_phase_start = 16'd1 << phase;

    // phi is high for the first half of the cycle
    assign clk_phi = ~phase[3];

    assign display_line = raster_line < 9'(visible_lines);

endmodule

// File: hires_pkg.sv
package hires_pkg;

    // display modes, the two plane encodings behave the same
    typedef enum logic [1:0] {
        mode_text       = 2'b00,
        mode_bitmap     = 2'b01,
        mode_planes     = 2'b10,
        mode_planes_alt = 2'b11
    } hires_mode_t;

    // dot4x ticks per phi cycle
    parameter int phase_count = 16;

    // cycles whose phase 2 starts a char, pixel and color fetch
    parameter int fetch_first_cycle = 14;
    parameter int fetch_last_cycle  = 53;

    // character positions on one display line
    parameter int chars_per_line = 40;

    // text mode view of the color byte
    typedef struct packed {
        logic [2:0] unused;
        logic       reverse;
        logic [3:0] fg;
    } color_text_t;

    // bitmap mode view, two colors per 8 pixels
    typedef struct packed {
        logic [3:0] fg;
        logic [3:0] bg;
    } color_bitmap_t;

    typedef union packed {
        color_text_t   text;
        color_bitmap_t bitmap;
    } color_byte_u;

endpackage
